//--- Makefile
# Verilator build and run for the MMIO subsystem testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
TOP        ?= mmio_subsystem_tb
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
PASS_TEXT  := *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/clint_pkg.sv
/* Timer count union with whole-count and half-word views,
   mtimecmp reset value and timer width constants */
package clint_pkg;

  // Bus-visible half of a 64-bit timer register
  localparam int unsigned TIMER_HALF_WIDTH = 32;

  // Full counter width
  localparam int unsigned TIMER_WIDTH = 2 * TIMER_HALF_WIDTH;

  // Compare starts at max so no interrupt fires before software sets it
  localparam logic [TIMER_WIDTH-1:0] MTIMECMP_RESET = '1;

  // Same 64 bits seen two ways
  // count is used for increment and compare
  // halves[0] is the low word, halves[1] the high word, as the bus sees them
  typedef union packed {
    logic [TIMER_WIDTH-1:0]                 count;
    logic [1:0][TIMER_HALF_WIDTH-1:0]       halves;
  } timer_count_u;

endpackage

//--- rtl/clint_timer.sv
/* CLINT-style timer: free-running mtime, mtimecmp, msip bit and the
   registered timer-interrupt level, written from the registered store */
`timescale 1ns/1ps

module clint_timer #(
  parameter int unsigned TIMER_STEP = 1
) (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_st_valid,
  input  mmio_map_pkg::mmio_target_e          i_st_target,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_st_data,
  output clint_pkg::timer_count_u             o_mtime,
  output clint_pkg::timer_count_u             o_mtimecmp,
  output logic                                o_msip,
  output logic                                o_mtip
);

  // Step widened to the counter
  localparam logic [clint_pkg::TIMER_WIDTH-1:0] STEP_COUNT = TIMER_STEP;

  logic wr_mtime_lo;
  logic wr_mtime_hi;
  logic wr_cmp_lo;
  logic wr_cmp_hi;
  logic wr_msip;

  // Register writes are live in N+1 of the store
  assign wr_mtime_lo = i_st_valid && (i_st_target == mmio_map_pkg::TGT_MTIME_LO);
  assign wr_mtime_hi = i_st_valid && (i_st_target == mmio_map_pkg::TGT_MTIME_HI);
  assign wr_cmp_lo   = i_st_valid && (i_st_target == mmio_map_pkg::TGT_MTIMECMP_LO);
  assign wr_cmp_hi   = i_st_valid && (i_st_target == mmio_map_pkg::TGT_MTIMECMP_HI);
  assign wr_msip     = i_st_valid && (i_st_target == mmio_map_pkg::TGT_MSIP);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mtime.count    <= '0;
      o_mtimecmp.count <= clint_pkg::MTIMECMP_RESET;
      o_msip           <= 1'b0;
    end else begin
      // Half write freezes the whole counter for that cycle
      // so the other half neither carries nor steps
      if (wr_mtime_lo) begin
        o_mtime.halves[0] <= i_st_data;
      end else if (wr_mtime_hi) begin
        o_mtime.halves[1] <= i_st_data;
      end else begin
        o_mtime.count <= o_mtime.count + STEP_COUNT;
      end

      // Compare halves are independent
      if (wr_cmp_lo) begin
        o_mtimecmp.halves[0] <= i_st_data;
      end
      if (wr_cmp_hi) begin
        o_mtimecmp.halves[1] <= i_st_data;
      end

      // Only bit 0 of MSIP is implemented
      if (wr_msip) begin
        o_msip <= i_st_data[0];
      end
    end
  end

  // 64-bit compare gets its own register stage
  // mtip lags the counters by one cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mtip <= 1'b0;
    end else begin
      o_mtip <= (o_mtime.count >= o_mtimecmp.count);
    end
  end

  // mtimecmp resets to max, so no interrupt right out of reset
  a_mtip_low_after_reset : assert property (
    @(posedge i_clk)
    $fell(i_rst) |=> !o_mtip
  ) else $error("mtip high in the cycle after reset");

endmodule

//--- rtl/data_ram.sv
/* Single-port data RAM, word addressed, per-lane writes, registered read */
`timescale 1ns/1ps

module data_ram #(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic                                i_clk,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_addr,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_wr_data,
  input  logic [mmio_map_pkg::BYTE_LANES-1:0] i_byte_we,
  output logic [mmio_map_pkg::WORD_WIDTH-1:0] o_rd_data
);

  // Byte address to word index
  localparam int unsigned INDEX_WIDTH = $clog2(MEM_WORDS);
  localparam int unsigned LANE_BITS   = $clog2(mmio_map_pkg::BYTE_LANES);

  logic [mmio_map_pkg::WORD_WIDTH-1:0] mem [MEM_WORDS];
  logic [INDEX_WIDTH-1:0]              index;

  // Upper address bits wrap, window addresses alias onto low words
  assign index = i_addr[LANE_BITS +: INDEX_WIDTH];

  // Lane-wise write
  always_ff @(posedge i_clk) begin
    for (int lane = 0; lane < mmio_map_pkg::BYTE_LANES; lane++) begin
      if (i_byte_we[lane]) begin
        mem[index][lane*8 +: 8] <= i_wr_data[lane*8 +: 8];
      end
    end
  end

  // Read-first, word for the cycle-N address shows up in N+1
  always_ff @(posedge i_clk) begin
    o_rd_data <= mem[index];
  end

endmodule

//--- rtl/mmio_load_stage.sv
/* Load stage: peripheral read select, capture register on the read pulse,
   final mux against RAM data and the FIFO pop / UART receive consume pulses */
`timescale 1ns/1ps

module mmio_load_stage (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_load_addr,
  input  logic                                i_load_valid,
  input  logic                                i_read_pulse,
  input  mmio_map_pkg::mmio_target_e          i_st_target,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_ram_rd_data,
  input  logic [7:0]                          i_uart_rx_data,
  input  logic                                i_uart_rx_valid,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_fifo0_rd_data,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_fifo1_rd_data,
  input  clint_pkg::timer_count_u             i_mtime,
  input  clint_pkg::timer_count_u             i_mtimecmp,
  input  logic                                i_msip,
  output logic [mmio_map_pkg::WORD_WIDTH-1:0] o_rd_data,
  output logic                                o_fifo0_rd_en,
  output logic                                o_fifo1_rd_en,
  output logic                                o_uart_rx_ready
);

  mmio_map_pkg::mmio_target_e          load_target;
  logic                                load_in_window;
  logic [mmio_map_pkg::WORD_WIDTH-1:0] periph_word;
  logic [mmio_map_pkg::WORD_WIDTH-1:0] capture_q;

  // Load address comes from the CPU's memory stage, held across L+1..
  assign load_target    = mmio_map_pkg::mmio_target_of(i_load_addr);
  assign load_in_window = i_load_valid && mmio_map_pkg::in_mmio_window(i_load_addr);

  // Read select; write-only and unmapped slots read as zero
  always_comb begin
    periph_word = '0;
    case (load_target)
      mmio_map_pkg::TGT_UART_RX_DATA:   periph_word = {24'b0, i_uart_rx_data};
      mmio_map_pkg::TGT_UART_RX_STATUS: periph_word = {31'b0, i_uart_rx_valid};
      mmio_map_pkg::TGT_FIFO0:          periph_word = i_fifo0_rd_data;
      mmio_map_pkg::TGT_FIFO1:          periph_word = i_fifo1_rd_data;
      mmio_map_pkg::TGT_MTIME_LO:       periph_word = i_mtime.halves[0];
      mmio_map_pkg::TGT_MTIME_HI:       periph_word = i_mtime.halves[1];
      mmio_map_pkg::TGT_MTIMECMP_LO:    periph_word = i_mtimecmp.halves[0];
      mmio_map_pkg::TGT_MTIMECMP_HI:    periph_word = i_mtimecmp.halves[1];
      mmio_map_pkg::TGT_MSIP:           periph_word = {31'b0, i_msip};
      default:                          periph_word = '0;
    endcase
  end

  // Capture in L+1, keeps FIFO/UART combinational paths out of the CPU
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      capture_q <= '0;
    end else if (i_read_pulse && load_in_window) begin
      capture_q <= periph_word;
    end
  end

  // Held capture while the load stays in the window, RAM otherwise
  assign o_rd_data = load_in_window ? capture_q : i_ram_rd_data;

  // Consume pulses pop the source in the same cycle the word is sampled
  assign o_fifo0_rd_en   = i_read_pulse && (i_st_target == mmio_map_pkg::TGT_FIFO0);
  assign o_fifo1_rd_en   = i_read_pulse && (i_st_target == mmio_map_pkg::TGT_FIFO1);
  assign o_uart_rx_ready = i_read_pulse && (i_st_target == mmio_map_pkg::TGT_UART_RX_DATA);

  // A single load consumes from at most one source
  a_one_consume : assert property (
    @(posedge i_clk) disable iff (i_rst)
    $onehot0({o_fifo0_rd_en, o_fifo1_rd_en, o_uart_rx_ready})
  ) else $error("More than one consume pulse in the same cycle");

endmodule

//--- rtl/mmio_map_pkg.sv
/* Bus widths, peripheral address map, register target enumeration
   and the address decode helpers for the MMIO window */
package mmio_map_pkg;

  // Data bus shape
  localparam int unsigned WORD_WIDTH = 32;
  localparam int unsigned BYTE_LANES = WORD_WIDTH / 8;

  // Peripheral window
  localparam logic [WORD_WIDTH-1:0] MMIO_BASE       = 32'h4000_0000;
  localparam logic [WORD_WIDTH-1:0] MMIO_SIZE_BYTES = 32'h0000_0028;

  // Register addresses, CLINT-like timer block in the middle
  localparam logic [WORD_WIDTH-1:0] UART_TX_ADDR        = MMIO_BASE + 32'h00;
  localparam logic [WORD_WIDTH-1:0] UART_RX_DATA_ADDR   = MMIO_BASE + 32'h04;
  localparam logic [WORD_WIDTH-1:0] FIFO0_ADDR          = MMIO_BASE + 32'h08;
  localparam logic [WORD_WIDTH-1:0] FIFO1_ADDR          = MMIO_BASE + 32'h0C;
  localparam logic [WORD_WIDTH-1:0] MTIME_LO_ADDR       = MMIO_BASE + 32'h10;
  localparam logic [WORD_WIDTH-1:0] MTIME_HI_ADDR       = MMIO_BASE + 32'h14;
  localparam logic [WORD_WIDTH-1:0] MTIMECMP_LO_ADDR    = MMIO_BASE + 32'h18;
  localparam logic [WORD_WIDTH-1:0] MTIMECMP_HI_ADDR    = MMIO_BASE + 32'h1C;
  localparam logic [WORD_WIDTH-1:0] MSIP_ADDR           = MMIO_BASE + 32'h20;
  localparam logic [WORD_WIDTH-1:0] UART_RX_STATUS_ADDR = MMIO_BASE + 32'h24;

  // One code per register, TGT_NONE for RAM or unmapped addresses
  typedef enum logic [3:0] {
    TGT_UART_TX,
    TGT_UART_RX_DATA,
    TGT_FIFO0,
    TGT_FIFO1,
    TGT_MTIME_LO,
    TGT_MTIME_HI,
    TGT_MTIMECMP_LO,
    TGT_MTIMECMP_HI,
    TGT_MSIP,
    TGT_UART_RX_STATUS,
    TGT_NONE
  } mmio_target_e;

  // Exact-match decode, unaligned addresses fall to TGT_NONE
  function automatic mmio_target_e mmio_target_of(input logic [WORD_WIDTH-1:0] addr);
    mmio_target_e tgt;
    case (addr)
      UART_TX_ADDR:        tgt = TGT_UART_TX;
      UART_RX_DATA_ADDR:   tgt = TGT_UART_RX_DATA;
      FIFO0_ADDR:          tgt = TGT_FIFO0;
      FIFO1_ADDR:          tgt = TGT_FIFO1;
      MTIME_LO_ADDR:       tgt = TGT_MTIME_LO;
      MTIME_HI_ADDR:       tgt = TGT_MTIME_HI;
      MTIMECMP_LO_ADDR:    tgt = TGT_MTIMECMP_LO;
      MTIMECMP_HI_ADDR:    tgt = TGT_MTIMECMP_HI;
      MSIP_ADDR:           tgt = TGT_MSIP;
      UART_RX_STATUS_ADDR: tgt = TGT_UART_RX_STATUS;
      default:             tgt = TGT_NONE;
    endcase
    return tgt;
  endfunction

  // Whole window, including holes between registers
  function automatic logic in_mmio_window(input logic [WORD_WIDTH-1:0] addr);
    return (addr >= MMIO_BASE) && (addr < (MMIO_BASE + MMIO_SIZE_BYTES));
  endfunction

endpackage

//--- rtl/mmio_store_stage.sv
/* Store stage: RAM write masking for the MMIO window, registered store
   flags for the timer and load path, FIFO push and UART transmit strobes */
`timescale 1ns/1ps

module mmio_store_stage (
  input  logic                                    i_clk,
  input  logic                                    i_rst,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0]     i_addr,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0]     i_wr_data,
  input  logic [mmio_map_pkg::BYTE_LANES-1:0]     i_byte_we,
  output logic [mmio_map_pkg::BYTE_LANES-1:0]     o_ram_byte_we,
  output logic                                    o_st_valid,
  output mmio_map_pkg::mmio_target_e              o_st_target,
  output logic [mmio_map_pkg::WORD_WIDTH-1:0]     o_st_data,
  output logic                                    o_fifo0_wr_en,
  output logic                                    o_fifo1_wr_en,
  output logic [mmio_map_pkg::WORD_WIDTH-1:0]     o_fifo_wr_data,
  output logic                                    o_uart_wr_en,
  output logic [7:0]                              o_uart_wr_data
);

  logic uart_hit;

  // Peripheral stores must not land in RAM at the aliased index
  assign o_ram_byte_we = mmio_map_pkg::in_mmio_window(i_addr) ? '0 : i_byte_we;

  // Cycle N+1 view of the store
  // Target is decoded from the address whether or not a store happened,
  // the load path uses it for its consume pulses
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_st_valid  <= 1'b0;
      o_st_target <= mmio_map_pkg::TGT_NONE;
    end else begin
      o_st_valid  <= |i_byte_we;
      o_st_target <= mmio_map_pkg::mmio_target_of(i_addr);
    end
  end

  // Payload, no reset needed
  always_ff @(posedge i_clk) begin
    o_st_data <= i_wr_data;
  end

  // FIFO pushes straight off the registered store, high in N+1
  assign o_fifo0_wr_en  = o_st_valid && (o_st_target == mmio_map_pkg::TGT_FIFO0);
  assign o_fifo1_wr_en  = o_st_valid && (o_st_target == mmio_map_pkg::TGT_FIFO1);
  assign o_fifo_wr_data = o_st_data;

  assign uart_hit = o_st_valid && (o_st_target == mmio_map_pkg::TGT_UART_TX);

  // UART gets one more register, strobe in N+2
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_uart_wr_en <= 1'b0;
    end else begin
      o_uart_wr_en <= uart_hit;
    end
  end

  // Only the low byte goes out on the wire
  always_ff @(posedge i_clk) begin
    o_uart_wr_data <= o_st_data[7:0];
  end

  // One store, one target: pushes are mutually exclusive
  a_fifo_push_exclusive : assert property (
    @(posedge i_clk) disable iff (i_rst)
    !(o_fifo0_wr_en && o_fifo1_wr_en)
  ) else $error("FIFO0 and FIFO1 push strobes high in the same cycle");

endmodule

//--- rtl/mmio_subsystem.sv
/* MMIO and data-memory subsystem top: store stage, data RAM,
   CLINT timer and load stage wired together */
`timescale 1ns/1ps

module mmio_subsystem #(
  parameter int unsigned MEM_WORDS  = 1024,
  parameter int unsigned TIMER_STEP = 1
) (
  input  logic                                i_clk,
  input  logic                                i_rst,
  // CPU data port
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_addr,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_wr_data,
  input  logic [mmio_map_pkg::BYTE_LANES-1:0] i_byte_we,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_load_addr,
  input  logic                                i_load_valid,
  input  logic                                i_read_pulse,
  output logic [mmio_map_pkg::WORD_WIDTH-1:0] o_rd_data,
  // UART
  output logic                                o_uart_wr_en,
  output logic [7:0]                          o_uart_wr_data,
  input  logic [7:0]                          i_uart_rx_data,
  input  logic                                i_uart_rx_valid,
  output logic                                o_uart_rx_ready,
  // FIFOs
  output logic                                o_fifo0_wr_en,
  output logic [mmio_map_pkg::WORD_WIDTH-1:0] o_fifo0_wr_data,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_fifo0_rd_data,
  output logic                                o_fifo0_rd_en,
  output logic                                o_fifo1_wr_en,
  output logic [mmio_map_pkg::WORD_WIDTH-1:0] o_fifo1_wr_data,
  input  logic [mmio_map_pkg::WORD_WIDTH-1:0] i_fifo1_rd_data,
  output logic                                o_fifo1_rd_en,
  // Interrupt levels
  output logic                                o_mtip,
  output logic                                o_msip
);

  logic [mmio_map_pkg::BYTE_LANES-1:0] ram_byte_we;
  logic [mmio_map_pkg::WORD_WIDTH-1:0] ram_rd_data;
  logic                                st_valid;
  mmio_map_pkg::mmio_target_e          st_target;
  logic [mmio_map_pkg::WORD_WIDTH-1:0] st_data;
  logic [mmio_map_pkg::WORD_WIDTH-1:0] fifo_wr_data;
  clint_pkg::timer_count_u             mtime;
  clint_pkg::timer_count_u             mtimecmp;

  // Both FIFOs see the same store data, the strobe picks one
  assign o_fifo0_wr_data = fifo_wr_data;
  assign o_fifo1_wr_data = fifo_wr_data;

  mmio_store_stage u_store (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_addr         (i_addr),
    .i_wr_data      (i_wr_data),
    .i_byte_we      (i_byte_we),
    .o_ram_byte_we  (ram_byte_we),
    .o_st_valid     (st_valid),
    .o_st_target    (st_target),
    .o_st_data      (st_data),
    .o_fifo0_wr_en  (o_fifo0_wr_en),
    .o_fifo1_wr_en  (o_fifo1_wr_en),
    .o_fifo_wr_data (fifo_wr_data),
    .o_uart_wr_en   (o_uart_wr_en),
    .o_uart_wr_data (o_uart_wr_data)
  );

  // RAM runs on the live address, in parallel with the timer
  data_ram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ram (
    .i_clk     (i_clk),
    .i_addr    (i_addr),
    .i_wr_data (i_wr_data),
    .i_byte_we (ram_byte_we),
    .o_rd_data (ram_rd_data)
  );

  clint_timer #(
    .TIMER_STEP (TIMER_STEP)
  ) u_timer (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_st_valid  (st_valid),
    .i_st_target (st_target),
    .i_st_data   (st_data),
    .o_mtime     (mtime),
    .o_mtimecmp  (mtimecmp),
    .o_msip      (o_msip),
    .o_mtip      (o_mtip)
  );

  mmio_load_stage u_load (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_load_addr     (i_load_addr),
    .i_load_valid    (i_load_valid),
    .i_read_pulse    (i_read_pulse),
    .i_st_target     (st_target),
    .i_ram_rd_data   (ram_rd_data),
    .i_uart_rx_data  (i_uart_rx_data),
    .i_uart_rx_valid (i_uart_rx_valid),
    .i_fifo0_rd_data (i_fifo0_rd_data),
    .i_fifo1_rd_data (i_fifo1_rd_data),
    .i_mtime         (mtime),
    .i_mtimecmp      (mtimecmp),
    .i_msip          (o_msip),
    .o_rd_data       (o_rd_data),
    .o_fifo0_rd_en   (o_fifo0_rd_en),
    .o_fifo1_rd_en   (o_fifo1_rd_en),
    .o_uart_rx_ready (o_uart_rx_ready)
  );

endmodule

//--- tb.f
rtl/mmio_map_pkg.sv
rtl/clint_pkg.sv
rtl/mmio_store_stage.sv
rtl/data_ram.sv
rtl/clint_timer.sv
rtl/mmio_load_stage.sv
rtl/mmio_subsystem.sv
verification/mmio_subsystem_tb.sv

//--- verification/mmio_subsystem_tb.sv
/* Testbench for mmio_subsystem with CPU data port stimulus, FIFO and UART
   receive models, strobe assertions, RAM/timer/MSIP checks and watchdog */
`timescale 1ns/1ps

module mmio_subsystem_tb;

  localparam int unsigned MEM_WORDS   = 1024;
  localparam int unsigned TIMER_STEP  = 3;
  localparam int unsigned CLK_PERIOD  = 20;
  // Rough sum of all test cycles with headroom
  localparam int unsigned TEST_CYCLES = 160;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

  logic        i_clk;
  logic        i_rst;
  logic [31:0] i_addr;
  logic [31:0] i_wr_data;
  logic [3:0]  i_byte_we;
  logic [31:0] i_load_addr;
  logic        i_load_valid;
  logic        i_read_pulse;
  logic [31:0] o_rd_data;
  logic        o_uart_wr_en;
  logic [7:0]  o_uart_wr_data;
  logic [7:0]  i_uart_rx_data;
  logic        i_uart_rx_valid;
  logic        o_uart_rx_ready;
  logic        o_fifo0_wr_en;
  logic [31:0] o_fifo0_wr_data;
  logic [31:0] i_fifo0_rd_data;
  logic        o_fifo0_rd_en;
  logic        o_fifo1_wr_en;
  logic [31:0] o_fifo1_wr_data;
  logic [31:0] i_fifo1_rd_data;
  logic        o_fifo1_rd_en;
  logic        o_mtip;
  logic        o_msip;

  logic [31:0] lfsr_state;

  mmio_subsystem #(
    .MEM_WORDS  (MEM_WORDS),
    .TIMER_STEP (TIMER_STEP)
  ) uut (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_addr (i_addr), .i_wr_data (i_wr_data), .i_byte_we (i_byte_we),
    .i_load_addr (i_load_addr), .i_load_valid (i_load_valid),
    .i_read_pulse (i_read_pulse), .o_rd_data (o_rd_data),
    .o_uart_wr_en (o_uart_wr_en), .o_uart_wr_data (o_uart_wr_data),
    .i_uart_rx_data (i_uart_rx_data), .i_uart_rx_valid (i_uart_rx_valid),
    .o_uart_rx_ready (o_uart_rx_ready),
    .o_fifo0_wr_en (o_fifo0_wr_en), .o_fifo0_wr_data (o_fifo0_wr_data),
    .i_fifo0_rd_data (i_fifo0_rd_data), .o_fifo0_rd_en (o_fifo0_rd_en),
    .o_fifo1_wr_en (o_fifo1_wr_en), .o_fifo1_wr_data (o_fifo1_wr_data),
    .i_fifo1_rd_data (i_fifo1_rd_data), .o_fifo1_rd_en (o_fifo1_rd_en),
    .o_mtip (o_mtip), .o_msip (o_msip)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  task automatic fail_run();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] next_rand(input int nbits);
    logic [31:0] result;
    logic        lsb;
    result = '0;
    for (int i = 0; i < nbits; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) lfsr_state = lfsr_state ^ LFSR_TAPS;
      result = {result[30:0], lsb};
    end
    return result;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  // Push strobe in N+1 only for a FIFO store and it carries the store data
  a_fifo0_push : assert property (@(posedge i_clk) disable iff (i_rst)
    (o_fifo0_wr_en == ($past(|i_byte_we) && $past(i_addr) == mmio_map_pkg::FIFO0_ADDR))
    && (!o_fifo0_wr_en || o_fifo0_wr_data == $past(i_wr_data)))
  else begin
    $display("ERR o_fifo0_wr_en 0x%h data 0x%h", o_fifo0_wr_en, o_fifo0_wr_data);
    fail_run();
  end

  a_fifo1_push : assert property (@(posedge i_clk) disable iff (i_rst)
    (o_fifo1_wr_en == ($past(|i_byte_we) && $past(i_addr) == mmio_map_pkg::FIFO1_ADDR))
    && (!o_fifo1_wr_en || o_fifo1_wr_data == $past(i_wr_data)))
  else begin
    $display("ERR o_fifo1_wr_en 0x%h data 0x%h", o_fifo1_wr_en, o_fifo1_wr_data);
    fail_run();
  end

  // UART byte goes out two cycles after the store
  a_uart_tx : assert property (@(posedge i_clk) disable iff (i_rst)
    (o_uart_wr_en == ($past(|i_byte_we, 2) && $past(i_addr, 2) == mmio_map_pkg::UART_TX_ADDR))
    && (!o_uart_wr_en || o_uart_wr_data == $past(i_wr_data[7:0], 2)))
  else begin
    $display("ERR o_uart_wr_en 0x%h data 0x%h", o_uart_wr_en, o_uart_wr_data);
    fail_run();
  end

  task automatic idle_cycle();
    @(posedge i_clk);
    i_byte_we    <= '0;
    i_read_pulse <= 1'b0;
    i_load_valid <= 1'b0;
  endtask

  task automatic store(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] we);
    @(posedge i_clk);
    i_addr       <= addr;
    i_wr_data    <= data;
    i_byte_we    <= we;
    i_read_pulse <= 1'b0;
    i_load_valid <= 1'b0;
  endtask

  // Address in cycle M and the RAM word on o_rd_data in M+1
  task automatic ram_read_check(input logic [31:0] addr, input logic [31:0] exp);
    @(posedge i_clk);
    i_addr       <= addr;
    i_byte_we    <= '0;
    i_load_valid <= 1'b0;
    @(posedge i_clk);
    @(negedge i_clk);
    check_word("o_rd_data (RAM)", o_rd_data, exp);
  endtask

  // Load protocol with addr in L, pulse in L+1 and word sampled in L+2
  // pulses = {fifo0_rd_en, fifo1_rd_en, uart_rx_ready} seen in L+1
  task automatic load_word(input logic [31:0] addr, output logic [31:0] data,
                           output logic [2:0] pulses);
    @(posedge i_clk);
    i_addr       <= addr;
    i_byte_we    <= '0;
    i_load_valid <= 1'b0;
    i_read_pulse <= 1'b0;
    @(posedge i_clk);
    i_load_addr  <= addr;
    i_load_valid <= 1'b1;
    i_read_pulse <= 1'b1;
    @(negedge i_clk);
    pulses = {o_fifo0_rd_en, o_fifo1_rd_en, o_uart_rx_ready};
    @(posedge i_clk);
    i_read_pulse <= 1'b0;
    @(negedge i_clk);
    data = o_rd_data;
  endtask

  task automatic wait_mtip(input logic want, input int max_cycles);
    int n;
    n = 0;
    @(negedge i_clk);
    while (o_mtip !== want) begin
      n++;
      if (n > max_cycles) begin
        $display("o_mtip did not reach %0d within %0d cycles", want, max_cycles);
        fail_run();
      end
      @(negedge i_clk);
    end
  endtask

  // Watchdog
  initial begin
    #(TEST_CYCLES * CLK_PERIOD + 500);
    $display("Watchdog expired before the tests finished");
    fail_run();
  end

  initial begin
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [7:0]  rx_byte;
    logic [2:0]  pulses;
    lfsr_state = 32'd28;
    i_clk = 1'b0;
    i_rst <= 1'b1;
    i_addr <= '0;
    i_wr_data <= '0;
    i_byte_we <= '0;
    i_load_addr <= '0;
    i_load_valid <= 1'b0;
    i_read_pulse <= 1'b0;
    i_uart_rx_data <= '0;
    i_uart_rx_valid <= 1'b0;
    i_fifo0_rd_data <= '0;
    i_fifo1_rd_data <= '0;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;

    // Compare register out of reset and no interrupt
    load_word(mmio_map_pkg::MTIMECMP_LO_ADDR, v1, pulses);
    check_word("o_rd_data (mtimecmp lo)", v1, 32'hffff_ffff);
    load_word(mmio_map_pkg::MTIMECMP_HI_ADDR, v1, pulses);
    check_word("o_rd_data (mtimecmp hi)", v1, 32'hffff_ffff);
    check_word("o_mtip", {31'b0, o_mtip}, 32'h0);

    // Full word then lane 0 merge
    w0 = next_rand(32);
    w1 = next_rand(32);
    store(32'h0000_0040, w0, 4'hf);
    store(32'h0000_0040, w1, 4'h1);
    ram_read_check(32'h0000_0040, {w0[31:8], w1[7:0]});

    // FIFO0 store aliases RAM index 2 and must not touch it
    w0 = next_rand(32);
    store(32'h0000_0008, w0, 4'hf);
    store(mmio_map_pkg::FIFO0_ADDR, next_rand(32), 4'hf);
    store(mmio_map_pkg::FIFO1_ADDR, next_rand(32), 4'hf);
    store(mmio_map_pkg::UART_TX_ADDR, next_rand(32), 4'hf);
    idle_cycle();
    idle_cycle();
    ram_read_check(32'h0000_0008, w0);

    // UART receive data and status
    rx_byte = 8'(next_rand(8));
    @(posedge i_clk);
    i_uart_rx_data  <= rx_byte;
    i_uart_rx_valid <= 1'b1;
    load_word(mmio_map_pkg::UART_RX_DATA_ADDR, v1, pulses);
    check_word("o_rd_data (uart rx data)", v1, {24'b0, rx_byte});
    check_word("o_fifo0_rd_en/o_fifo1_rd_en/o_uart_rx_ready (uart)", {29'b0, pulses}, 32'h1);
    load_word(mmio_map_pkg::UART_RX_STATUS_ADDR, v1, pulses);
    check_word("o_rd_data (uart rx status)", v1, 32'h1);
    check_word("o_fifo0_rd_en/o_fifo1_rd_en/o_uart_rx_ready (status)", {29'b0, pulses}, 32'h0);
    @(posedge i_clk);
    i_uart_rx_valid <= 1'b0;
    load_word(mmio_map_pkg::UART_RX_STATUS_ADDR, v1, pulses);
    check_word("o_rd_data (uart rx status)", v1, 32'h0);

    // FIFO pops
    w0 = next_rand(32);
    w1 = next_rand(32);
    @(posedge i_clk);
    i_fifo0_rd_data <= w0;
    i_fifo1_rd_data <= w1;
    load_word(mmio_map_pkg::FIFO0_ADDR, v1, pulses);
    check_word("o_rd_data (fifo0)", v1, w0);
    check_word("o_fifo0_rd_en/o_fifo1_rd_en/o_uart_rx_ready (fifo0)", {29'b0, pulses}, 32'h4);
    load_word(mmio_map_pkg::FIFO1_ADDR, v1, pulses);
    check_word("o_rd_data (fifo1)", v1, w1);
    check_word("o_fifo0_rd_en/o_fifo1_rd_en/o_uart_rx_ready (fifo1)", {29'b0, pulses}, 32'h2);

    // mtime advance between captures 7 cycles apart
    load_word(mmio_map_pkg::MTIME_LO_ADDR, v1, pulses);
    repeat (4) idle_cycle();
    load_word(mmio_map_pkg::MTIME_LO_ADDR, v2, pulses);
    check_word("o_rd_data delta (mtime lo)", v2 - v1, 32'(7 * TIMER_STEP));

    // mtime low write then a read captured two cycles after it lands
    w0 = next_rand(32);
    store(mmio_map_pkg::MTIME_LO_ADDR, w0, 4'hf);
    idle_cycle();
    idle_cycle();
    load_word(mmio_map_pkg::MTIME_LO_ADDR, v1, pulses);
    check_word("o_rd_data (mtime lo after write)", v1, w0 + 32'(2 * TIMER_STEP));

    // Compare below mtime raises mtip and holds it
    store(mmio_map_pkg::MTIMECMP_HI_ADDR, 32'h0, 4'hf);
    store(mmio_map_pkg::MTIMECMP_LO_ADDR, 32'h0, 4'hf);
    idle_cycle();
    wait_mtip(1'b1, 2);
    repeat (3) idle_cycle();
    @(negedge i_clk);
    check_word("o_mtip", {31'b0, o_mtip}, 32'h1);
    store(mmio_map_pkg::MTIMECMP_LO_ADDR, 32'hffff_ffff, 4'hf);
    store(mmio_map_pkg::MTIMECMP_HI_ADDR, 32'hffff_ffff, 4'hf);
    idle_cycle();
    wait_mtip(1'b0, 4);

    // Software interrupt set, read back and clear
    store(mmio_map_pkg::MSIP_ADDR, 32'h1, 4'hf);
    idle_cycle();
    idle_cycle();
    @(negedge i_clk);
    check_word("o_msip", {31'b0, o_msip}, 32'h1);
    load_word(mmio_map_pkg::MSIP_ADDR, v1, pulses);
    check_word("o_rd_data (msip)", v1, 32'h1);
    store(mmio_map_pkg::MSIP_ADDR, 32'h0, 4'hf);
    idle_cycle();
    idle_cycle();
    @(negedge i_clk);
    check_word("o_msip", {31'b0, o_msip}, 32'h0);

    idle_cycle();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
